//--- Makefile
# Verilator build and run of the AFI PHY testbench

TOP := afi_phy_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- bench/afi_phy_assertions.sv
`include "afi_phy_cfg.svh"

module afi_phy_assertions
	import afi_phy_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset,
	input logic dqs_en,
	input logic oct_en,
	input afi_wr_t wr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pslverr,
	input shift_t ac_shift,
	input shift_t wlat,
	input logic mem_stable,
	input logic mem_clk_disable,
	input logic [`CALIB_REG_W-1:0] calib_skip_steps
);

	timeunit 1ns;
	timeprecision 100ps;

	// Strobe preamble opens the cycle before the first word of a burst
	dqs_preamble: assert property (@(posedge pll_afi_clk) disable iff (reset)
		$rose(wr.valid) |-> $past(dqs_en))
		else $error("first write word without a dqs_en preamble");

	// Termination still on in the cycle the strobe window closes
	oct_postamble: assert property (@(posedge pll_afi_clk) disable iff (reset)
		$fell(dqs_en) |-> oct_en)
		else $error("oct_en dropped together with dqs_en");

	// Termination closes exactly one cycle after the strobe
	oct_close: assert property (@(posedge pll_afi_clk) disable iff (reset)
		$fell(oct_en) |-> (!$past(dqs_en) && $past(dqs_en, 2)))
		else $error("oct_en did not close one cycle after dqs_en");

	// Registers only change on a write access to a defined address
	regs_hold: assert property (@(posedge pll_afi_clk) disable iff (reset)
		!(psel && penable && pwrite && !pslverr)
		|=> $stable({ac_shift, wlat, mem_stable, mem_clk_disable, calib_skip_steps}))
		else $error("configuration register changed without a valid APB write");

endmodule

bind afi_phy_top afi_phy_assertions u_assert (
	.pll_afi_clk(pll_afi_clk),
	.reset(reset),
	.dqs_en(dqs_en),
	.oct_en(oct_en),
	.wr(wr_slot),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.pslverr(pslverr),
	.ac_shift(ac_shift),
	.wlat(wlat),
	.mem_stable(mem_stable),
	.mem_clk_disable(mem_clk_disable),
	.calib_skip_steps(calib_skip_steps)
);

//--- bench/afi_phy_tb.sv
`include "afi_phy_cfg.svh"

module afi_phy_tb
	import afi_phy_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int CMD_LEN = 12;
	localparam int BURST_LEN = 6;
	localparam int GATE_LEN = 8;
	localparam int APB_CYCLES = 3;
	localparam int APB_TRANSFERS = 30;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + APB_TRANSFERS * APB_CYCLES
		+ GATE_LEN + 2 + 3 * (CMD_LEN + 2 + `MAX_SHIFT)
		+ 2 * (BURST_LEN + 6 + `MAX_SHIFT) + 16 + 100;
	localparam logic [31:0] LFSR_SEED = 32'd39;
	localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

	// Readable bits of each register
	localparam logic [`APB_DATA_W-1:0] CTRL_MASK = 32'h0000_0003;
	localparam logic [`APB_DATA_W-1:0] LAT_MASK = 32'h0000_0077;
	localparam logic [`APB_DATA_W-1:0] CALIB_MASK = 32'h0000_00FF;
	localparam logic [`APB_ADDR_W-1:0] BAD_ADDR = 8'h0C;

	logic pll_afi_clk;
	logic reset;
	afi_cmd_t afi_cmd;
	afi_wr_t afi_wr;
	logic [`APB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_DATA_W-1:0] pwdata;
	logic [`APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	mem_bus_t mem;
	logic mem_ck_en;
	logic [`CALIB_REG_W-1:0] calib_skip_steps;

	logic [31:0] lfsr_state;
	int cmd_errors;
	int wr_errors;
	int bit_errors;
	int reg_errors;
	int timing_errors;

	afi_phy_top dut (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.afi_cmd(afi_cmd),
		.afi_wr(afi_wr),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.mem(mem),
		.mem_ck_en(mem_ck_en),
		.calib_skip_steps(calib_skip_steps)
	);

	always #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;

	// One Galois step per bit
	function automatic logic rand_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ LFSR_POLY;
		return b;
	endfunction

	function automatic afi_cmd_t rand_cmd();
		logic [$bits(afi_cmd_t)-1:0] v;
		for (int i = 0; i < $bits(afi_cmd_t); i++)
			v[i] = rand_bit();
		return v;
	endfunction

	function automatic afi_wr_t rand_wr();
		afi_wr_t w;
		for (int i = 0; i < `AFI_DATA_W; i++)
			w.wdata[i] = rand_bit();
		for (int i = 0; i < `AFI_DM_W; i++)
			w.dm[i] = rand_bit();
		w.valid = 1'b1;
		return w;
	endfunction

	// DDR NOP with the memory deselected and held in reset
	function automatic afi_cmd_t nop_cmd();
		afi_cmd_t c;
		c = '0;
		c.cs_n = '1;
		c.ras_n = 1'b1;
		c.cas_n = 1'b1;
		c.we_n = 1'b1;
		return c;
	endfunction

	task automatic check_cmd(input string name, input afi_cmd_t got, input afi_cmd_t exp);
		if (got !== exp)
		begin
			cmd_errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_wr(input string name, input afi_wr_t got, input afi_wr_t exp);
		if (got !== exp)
		begin
			wr_errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			bit_errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input logic [`APB_DATA_W-1:0] got,
		input logic [`APB_DATA_W-1:0] exp);
		if (got !== exp)
		begin
			reg_errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// Responses are sampled a quarter period into the access phase
	task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
		input logic [`APB_DATA_W-1:0] data, input logic exp_err);
		@(negedge pll_afi_clk);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge pll_afi_clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		check_bit("pready", pready, 1'b1);
		check_bit("pslverr", pslverr, exp_err);
		@(negedge pll_afi_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr,
		output logic [`APB_DATA_W-1:0] data, input logic exp_err);
		@(negedge pll_afi_clk);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge pll_afi_clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		check_bit("pready", pready, 1'b1);
		check_bit("pslverr", pslverr, exp_err);
		data = prdata;
		@(negedge pll_afi_clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic test_reset_state();
		logic [`APB_DATA_W-1:0] rd;
		logic [`APB_DATA_W-1:0] calib;
		calib = '0;
		calib[`CALIB_REG_W-1:0] = calib_skip_steps;
		@(negedge pll_afi_clk);
		check_cmd("mem.cmd", mem.cmd, nop_cmd());
		check_bit("mem.dqs_en", mem.dqs_en, 1'b0);
		check_bit("mem.oct_en", mem.oct_en, 1'b0);
		check_bit("mem.dq_oe", mem.dq_oe, 1'b0);
		check_bit("mem_ck_en", mem_ck_en, 1'b1);
		check_reg("calib_skip_steps", calib, CALIB_MASK);
		apb_read(`REG_CTRL, rd, 1'b0);
		check_reg("prdata REG_CTRL", rd, 32'h0);
		apb_read(`REG_LAT, rd, 1'b0);
		check_reg("prdata REG_LAT", rd, 32'h0);
		apb_read(`REG_CALIB, rd, 1'b0);
		check_reg("prdata REG_CALIB", rd, CALIB_MASK);
	endtask

	task automatic test_apb_access();
		logic [`APB_DATA_W-1:0] rd;
		apb_write(`REG_LAT, 32'hFFFF_FFA5, 1'b0);
		apb_read(`REG_LAT, rd, 1'b0);
		check_reg("prdata REG_LAT", rd, 32'hFFFF_FFA5 & LAT_MASK);
		apb_write(`REG_CTRL, 32'hFFFF_FFFE, 1'b0);
		apb_read(`REG_CTRL, rd, 1'b0);
		check_reg("prdata REG_CTRL", rd, 32'hFFFF_FFFE & CTRL_MASK);
		apb_write(`REG_CALIB, 32'h1234_5A5C, 1'b0);
		apb_read(`REG_CALIB, rd, 1'b0);
		check_reg("prdata REG_CALIB", rd, 32'h1234_5A5C & CALIB_MASK);
		check_reg("calib_skip_steps", 32'(calib_skip_steps), 32'h1234_5A5C & CALIB_MASK);
		// Undefined address errors out and leaves every register alone
		apb_write(BAD_ADDR, 32'hFFFF_FFFF, 1'b1);
		apb_read(BAD_ADDR, rd, 1'b1);
		apb_read(`REG_LAT, rd, 1'b0);
		check_reg("prdata REG_LAT", rd, 32'hFFFF_FFA5 & LAT_MASK);
		apb_read(`REG_CTRL, rd, 1'b0);
		check_reg("prdata REG_CTRL", rd, 32'hFFFF_FFFE & CTRL_MASK);
		apb_read(`REG_CALIB, rd, 1'b0);
		check_reg("prdata REG_CALIB", rd, 32'h1234_5A5C & CALIB_MASK);
		apb_write(`REG_CTRL, 32'h0, 1'b0);
		apb_write(`REG_LAT, 32'h0, 1'b0);
	endtask

	// Command driven at one falling edge shows on mem 2+shift falling edges later
	task automatic run_cmd_stream(input int shift, input int count);
		afi_cmd_t sent [$];
		afi_cmd_t c;
		int lat;
		lat = 2 + shift;
		for (int i = 0; i < count + lat; i++)
		begin
			@(negedge pll_afi_clk);
			if (i >= lat)
				check_cmd("mem.cmd", mem.cmd, sent[i - lat]);
			if (i < count)
			begin
				c = rand_cmd();
				sent.push_back(c);
				afi_cmd = c;
			end
			else
				afi_cmd = nop_cmd();
		end
	endtask

	task automatic test_init_gating();
		apb_write(`REG_CTRL, 32'h0, 1'b0);
		for (int i = 0; i < GATE_LEN + 2; i++)
		begin
			@(negedge pll_afi_clk);
			check_cmd("mem.cmd", mem.cmd, nop_cmd());
			if (i < GATE_LEN)
				afi_cmd = rand_cmd();
			else
				afi_cmd = nop_cmd();
		end
		apb_write(`REG_CTRL, 32'h1, 1'b0);
		run_cmd_stream(0, CMD_LEN);
	endtask

	task automatic test_cmd_latency();
		apb_write(`REG_LAT, 32'h0, 1'b0);
		run_cmd_stream(0, CMD_LEN);
		apb_write(`REG_LAT, 32'h5, 1'b0);
		run_cmd_stream(5, CMD_LEN);
	endtask

	// Data at 3+wlat, strobe one cycle earlier, termination one cycle later
	task automatic run_write_burst(input int wlat, input int len);
		afi_wr_t sent [$];
		afi_wr_t w;
		afi_wr_t got;
		int lat;
		lat = 3 + wlat;
		for (int i = 0; i < len + lat + 3; i++)
		begin
			@(negedge pll_afi_clk);
			check_bit("mem.dqs_en", mem.dqs_en, (i >= lat - 1) && (i < lat + len));
			check_bit("mem.dq_oe", mem.dq_oe, (i >= lat - 1) && (i < lat + len));
			check_bit("mem.oct_en", mem.oct_en, (i >= lat - 1) && (i <= lat + len));
			if (i >= lat && i < lat + len)
			begin
				got.wdata = mem.dq;
				got.dm = mem.dm;
				got.valid = mem.dq_oe;
				check_wr("mem.dq/dm", got, sent[i - lat]);
			end
			if (i < len)
			begin
				w = rand_wr();
				sent.push_back(w);
				afi_wr = w;
			end
			else
				afi_wr = '0;
		end
	endtask

	task automatic test_write_burst();
		apb_write(`REG_LAT, 32'h00, 1'b0);
		run_write_burst(0, BURST_LEN);
		apb_write(`REG_LAT, 32'h30, 1'b0);
		run_write_burst(3, BURST_LEN);
	endtask

	task automatic await_ck_en(input logic level);
		int waited;
		waited = 0;
		while (mem_ck_en !== level && waited < 2)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		if (mem_ck_en !== level)
		begin
			timing_errors++;
			$display("mem_ck_en did not reach %0b within two cycles of the APB access", level);
		end
	endtask

	task automatic test_clock_disable();
		check_bit("mem_ck_en", mem_ck_en, 1'b1);
		apb_write(`REG_CTRL, 32'h3, 1'b0);
		await_ck_en(1'b0);
		apb_write(`REG_CTRL, 32'h1, 1'b0);
		await_ck_en(1'b1);
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		pll_afi_clk = 1'b0;
		reset = 1'b1;
		afi_cmd = nop_cmd();
		afi_wr = '0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		lfsr_state = LFSR_SEED;
		cmd_errors = 0;
		wr_errors = 0;
		bit_errors = 0;
		reg_errors = 0;
		timing_errors = 0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		reset = 1'b0;
		test_reset_state();
		test_apb_access();
		test_init_gating();
		test_cmd_latency();
		test_write_burst();
		test_clock_disable();
		$display("Errors: cmd %0d, wr %0d, bit %0d, reg %0d, timing %0d",
			cmd_errors, wr_errors, bit_errors, reg_errors, timing_errors);
		if (cmd_errors + wr_errors + bit_errors + reg_errors + timing_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- source/addr_cmd_path.sv
`include "afi_phy_cfg.svh"

module addr_cmd_path
	import afi_phy_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset,
	input afi_cmd_t afi_cmd,
	input shift_t ac_shift,
	input logic mem_stable,
	output afi_cmd_t cmd
);

	afi_cmd_t cmd_dly;

	// Command slots leave 1+ac_shift cycles after entry
	afi_delay_line #(
		.payload_t(afi_cmd_t),
		.DEPTH(`MAX_SHIFT)
	) u_cmd_dly (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.tap(ac_shift),
		.d(afi_cmd),
		.q(cmd_dly)
	);

	// Hold the memory deselected and in reset until it is marked stable
	always_comb
	begin
		if (mem_stable)
			cmd = cmd_dly;
		else
			cmd = AFI_NOP;
	end

endmodule

//--- source/afi_delay_line.sv
`include "afi_phy_cfg.svh"

module afi_delay_line
	import afi_phy_pkg::*;
#(
	parameter type payload_t = logic,
	parameter int DEPTH = `MAX_SHIFT
)
(
	input logic pll_afi_clk,
	input logic reset,
	input shift_t tap,
	input payload_t d,
	output payload_t q
);

	// DEPTH-1 chain stages plus the output register
	payload_t stage [DEPTH-1];
	shift_t sel;

	assign sel = tap - shift_t'(1);

	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH - 1; i++)
				stage[i] <= '0;
			q <= '0;
		end
		else
		begin
			stage[0] <= d;
			for (int i = 1; i < DEPTH - 1; i++)
				stage[i] <= stage[i-1];
			// Tap 0 bypasses the chain and takes one cycle through the output register
			q <= (tap == '0) ? d : stage[sel];
		end
	end

endmodule

//--- source/afi_phy_cfg.svh
`ifndef AFI_PHY_CFG_SVH
`define AFI_PHY_CFG_SVH

// AFI bus widths for a single rank at full rate
`define AFI_ADDR_W 15
`define AFI_BA_W 3
`define AFI_CS_W 1
`define AFI_DATA_W 32
`define AFI_DM_W 4

// Programmable delay lines
`define MAX_SHIFT 8
`define SHIFT_W 3

// Calibration skip-steps register
`define CALIB_REG_W 8

// APB bus and register map
`define APB_ADDR_W 8
`define APB_DATA_W 32
`define REG_CTRL `APB_ADDR_W'('h0)
`define REG_LAT `APB_ADDR_W'('h4)
`define REG_CALIB `APB_ADDR_W'('h8)

`endif

//--- source/afi_phy_pkg.sv
`include "afi_phy_cfg.svh"

package afi_phy_pkg;

	// Tap select for the programmable delay lines
	typedef logic [`SHIFT_W-1:0] shift_t;

	// One address/command slot as seen on the AFI side
	typedef struct packed
	{
		logic [`AFI_ADDR_W-1:0] addr;
		logic [`AFI_BA_W-1:0] ba;
		logic [`AFI_CS_W-1:0] cs_n;
		logic [`AFI_CS_W-1:0] cke;
		logic [`AFI_CS_W-1:0] odt;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic rst_n;
	} afi_cmd_t;

	// One write data slot
	typedef struct packed
	{
		logic [`AFI_DATA_W-1:0] wdata;
		logic [`AFI_DM_W-1:0] dm;
		logic valid;
	} afi_wr_t;

	// Registered word driven towards the memory pins
	typedef struct packed
	{
		afi_cmd_t cmd;
		logic [`AFI_DATA_W-1:0] dq;
		logic [`AFI_DM_W-1:0] dm;
		logic dqs_en;
		logic oct_en;
		logic dq_oe;
	} mem_bus_t;

	// Safe idle command that deselects the memory and holds it in reset
	localparam afi_cmd_t AFI_NOP = '{
		addr: '0,
		ba: '0,
		cs_n: '1,
		cke: '0,
		odt: '0,
		ras_n: 1'b1,
		cas_n: 1'b1,
		we_n: 1'b1,
		rst_n: 1'b0
	};

endpackage

//--- source/afi_phy_top.sv
`include "afi_phy_cfg.svh"

module afi_phy_top
	import afi_phy_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset,
	input afi_cmd_t afi_cmd,
	input afi_wr_t afi_wr,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_DATA_W-1:0] pwdata,
	output logic [`APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output mem_bus_t mem,
	output logic mem_ck_en,
	output logic [`CALIB_REG_W-1:0] calib_skip_steps
);

	shift_t ac_shift;
	shift_t wlat;
	logic mem_stable;
	logic mem_clk_disable;
	afi_cmd_t ac_cmd;
	afi_wr_t wr_slot;
	logic dqs_en;
	logic oct_en;

	phy_regs u_regs (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.ac_shift(ac_shift),
		.wlat(wlat),
		.mem_stable(mem_stable),
		.mem_clk_disable(mem_clk_disable),
		.calib_skip_steps(calib_skip_steps)
	);

	addr_cmd_path u_ac (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.afi_cmd(afi_cmd),
		.ac_shift(ac_shift),
		.mem_stable(mem_stable),
		.cmd(ac_cmd)
	);

	write_path u_wr (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.afi_wr(afi_wr),
		.wlat(wlat),
		.wr(wr_slot),
		.dqs_en(dqs_en),
		.oct_en(oct_en)
	);

	mem_out_stage u_out (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.cmd(ac_cmd),
		.wr(wr_slot),
		.dqs_en(dqs_en),
		.oct_en(oct_en),
		.mem_clk_disable(mem_clk_disable),
		.mem(mem),
		.mem_ck_en(mem_ck_en)
	);

endmodule

//--- source/mem_out_stage.sv
`include "afi_phy_cfg.svh"

module mem_out_stage
	import afi_phy_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset,
	input afi_cmd_t cmd,
	input afi_wr_t wr,
	input logic dqs_en,
	input logic oct_en,
	input logic mem_clk_disable,
	output mem_bus_t mem,
	output logic mem_ck_en
);

	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			mem.cmd <= AFI_NOP;
			mem.dq <= '0;
			mem.dm <= '0;
			mem.dqs_en <= 1'b0;
			mem.oct_en <= 1'b0;
			mem.dq_oe <= 1'b0;
			mem_ck_en <= 1'b1;
		end
		else
		begin
			mem.cmd <= cmd;
			mem.dq <= wr.wdata;
			mem.dm <= wr.dm;
			mem.dqs_en <= dqs_en;
			mem.oct_en <= oct_en;
			// DQ drivers open with the strobe window
			mem.dq_oe <= dqs_en;
			mem_ck_en <= ~mem_clk_disable;
		end
	end

endmodule

//--- source/phy_regs.sv
`include "afi_phy_cfg.svh"

module phy_regs
	import afi_phy_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_DATA_W-1:0] pwdata,
	output logic [`APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output shift_t ac_shift,
	output shift_t wlat,
	output logic mem_stable,
	output logic mem_clk_disable,
	output logic [`CALIB_REG_W-1:0] calib_skip_steps
);

	logic addr_hit;
	logic access;

	// No wait states
	assign pready = 1'b1;
	assign access = psel & penable;

	// Read mux and address decode
	always_comb
	begin
		prdata = '0;
		addr_hit = 1'b1;
		case (paddr)
			`REG_CTRL:
				prdata[1:0] = {mem_clk_disable, mem_stable};
			`REG_LAT:
			begin
				prdata[`SHIFT_W-1:0] = ac_shift;
				prdata[4 +: `SHIFT_W] = wlat;
			end
			`REG_CALIB:
				prdata[`CALIB_REG_W-1:0] = calib_skip_steps;
			default:
				addr_hit = 1'b0;
		endcase
	end

	assign pslverr = access & ~addr_hit;

	// Writes land on the access-phase edge
	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			mem_stable <= 1'b0;
			mem_clk_disable <= 1'b0;
			ac_shift <= '0;
			wlat <= '0;
			calib_skip_steps <= '1;
		end
		else if (access && pwrite)
		begin
			case (paddr)
				`REG_CTRL:
				begin
					mem_stable <= pwdata[0];
					mem_clk_disable <= pwdata[1];
				end
				`REG_LAT:
				begin
					ac_shift <= pwdata[`SHIFT_W-1:0];
					wlat <= pwdata[4 +: `SHIFT_W];
				end
				`REG_CALIB:
					calib_skip_steps <= pwdata[`CALIB_REG_W-1:0];
				default:
					;
			endcase
		end
	end

endmodule

//--- source/write_path.sv
`include "afi_phy_cfg.svh"

module write_path
	import afi_phy_pkg::*;
(
	input logic pll_afi_clk,
	input logic reset,
	input afi_wr_t afi_wr,
	input shift_t wlat,
	output afi_wr_t wr,
	output logic dqs_en,
	output logic oct_en
);

	afi_wr_t wr_dly;
	logic oct_post;

	// Write slots leave the line 1+wlat cycles after entry
	afi_delay_line #(
		.payload_t(afi_wr_t),
		.DEPTH(`MAX_SHIFT)
	) u_wr_dly (
		.pll_afi_clk(pll_afi_clk),
		.reset(reset),
		.tap(wlat),
		.d(afi_wr),
		.q(wr_dly)
	);

	// Extra stage so the line output acts as a one-cycle look-ahead
	always_ff @(posedge pll_afi_clk)
	begin
		if (reset)
		begin
			wr <= '0;
			oct_post <= 1'b0;
		end
		else
		begin
			wr <= wr_dly;
			oct_post <= wr.valid;
		end
	end

	// Preamble opens one cycle ahead of the first word
	assign dqs_en = wr_dly.valid | wr.valid;

	// Termination stays on for one cycle past the burst
	assign oct_en = dqs_en | oct_post;

endmodule

//--- src.f
+incdir+source
source/afi_phy_pkg.sv
source/afi_delay_line.sv
source/addr_cmd_path.sv
source/write_path.sv
source/phy_regs.sv
source/mem_out_stage.sv
source/afi_phy_top.sv
bench/afi_phy_assertions.sv
bench/afi_phy_tb.sv
